// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - files:
      - verilog/memStagePkg.sv
      - verilog/memDecode.sv
      - verilog/exceptionUnit.sv
      - verilog/cp0Regs.sv
      - verilog/memResult.sv
      - verilog/memStage.sv
  - target: test
    files:
      - verification/memStageTb.sv

// ==== project.f ====
verilog/memStagePkg.sv
verilog/memDecode.sv
verilog/exceptionUnit.sv
verilog/cp0Regs.sv
verilog/memResult.sv
verilog/memStage.sv
verification/memStageTb.sv

// ==== verification/memStageTb.sv ====
//==========================================================================
// memStageTb drives the MIPS32 memory stage from a test file and checks
// forwarding, dcache requests, CP0 moves, exceptions, interrupts and ERET
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module memStageTb
    import memStagePkg::*;
();

    // one cycle of stimulus plus what the stage should show for it
    typedef struct packed {
        exeMemBus    bus;
        logic        flush;
        logic        stall;
        logic [5:0]  irq;
        logic        disWr;
        logic [4:0]  mask;      // 1 fwd, 2 readOut, 4 dreq, 8 entry, 10 epc
        logic [31:0] fwd;
        logic        regWr;
        logic [31:0] rdo;
        logic        dValid;
        entrySel     entry;
        logic [31:0] vector;
        logic        flushAll;
        logic [31:0] epc;
    } testLine;

    logic        clk;
    logic        rstN;
    exeMemBus    exeIn;
    logic        flush;
    logic        stall;
    logic [5:0]  interrupt;
    logic        disWr;
    logic [31:0] fwdResult;
    logic [4:0]  fwdDst;
    logic        fwdRegWr;
    logic [31:0] readOut;
    dcacheReq    dreq;
    logic        ifFlush;
    logic        idFlush;
    logic        exeFlush;
    logic        memFlush;
    entrySel     excEntry;
    logic [31:0] vecOut;
    logic [31:0] epc;
    logic [31:0] memPc;

    testLine     tests[$];
    int          numTests;
    logic        loaded;
    exeMemBus    held;      // bundle sitting in the stage register

    memStage #(
        .bootVector (32'hbfc0_0380),
        .ebaseReset (32'h8000_0000)
    ) memStage_inst (
        .clk       (clk),
        .rstN      (rstN),
        .exeIn     (exeIn),
        .flush     (flush),
        .stall     (stall),
        .interrupt (interrupt),
        .disWr     (disWr),
        .fwdResult (fwdResult),
        .fwdDst    (fwdDst),
        .fwdRegWr  (fwdRegWr),
        .readOut   (readOut),
        .dreq      (dreq),
        .ifFlush   (ifFlush),
        .idFlush   (idFlush),
        .exeFlush  (exeFlush),
        .memFlush  (memFlush),
        .excEntry  (excEntry),
        .excVector (vecOut),
        .epc       (epc),
        .memPc     (memPc)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
            abortRun($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, name, got, exp));
    endtask

    function automatic string formatDreq(input dcacheReq r);
        return $sformatf("v%b w%b a%h d%h s%h l%h", r.valid, r.write, r.addr, r.wdata,
                         r.wstrb, r.load);
    endfunction

    task automatic checkDreq(input dcacheReq got, input dcacheReq exp);
        if (got !== exp)
            abortRun($sformatf("mismatch at %0t: dreq %s, expected %s", $time,
                               formatDreq(got), formatDreq(exp)));
    endtask

    task automatic checkEntry(input entrySel gotSel, input logic [31:0] gotVec,
                              input logic [3:0] gotFlush, input entrySel expSel,
                              input logic [31:0] expVec, input logic [3:0] expFlush);
        if (gotSel !== expSel || gotVec !== expVec || gotFlush !== expFlush)
            abortRun($sformatf("mismatch at %0t: entry %0d %h flush %b, expected %0d %h %b",
                               $time, gotSel, gotVec, gotFlush, expSel, expVec, expFlush));
    endtask

    function automatic testLine packColumns(input logic [31:0] c [0:27]);
        testLine t;
        t.bus.valid          = c[0][0];
        t.bus.aluOut         = c[1];
        t.bus.outB           = c[2];
        t.bus.pc             = c[3];
        t.bus.instr          = c[4];
        t.bus.load           = c[5][3:0];
        t.bus.store          = c[6][2:0];
        t.bus.wbSel          = wbSel'(c[7][1:0]);
        t.bus.rdSel          = regsRdSel'(c[8][1:0]);
        t.bus.dst            = c[9][4:0];
        t.bus.regWr          = c[10][0];
        t.bus.byteEn         = c[11][3:0];
        t.bus.except         = c[12][7:0];
        t.bus.isBranchOrJump = c[13][0];
        t.bus.isMtc0         = c[14][0];
        t.flush    = c[15][0];
        t.stall    = c[16][0];
        t.irq      = c[17][5:0];
        t.disWr    = c[18][0];
        t.mask     = c[19][4:0];
        t.fwd      = c[20];
        t.regWr    = c[21][0];
        t.rdo      = c[22];
        t.dValid   = c[23][0];
        t.entry    = entrySel'(c[24][1:0]);
        t.vector   = c[25];
        t.flushAll = c[26][0];
        t.epc      = c[27];
        return t;
    endfunction

    task automatic loadTests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] c [0:27];
        fd = $fopen("verification/memStageTests.txt", "r");
        if (fd == 0)
            abortRun("could not open verification/memStageTests.txt");
        else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments
                    n = $sscanf(line,
                                "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                                c[0], c[1], c[2], c[3], c[4], c[5], c[6],
                                c[7], c[8], c[9], c[10], c[11], c[12], c[13], c[14],
                                c[15], c[16], c[17], c[18], c[19], c[20], c[21],
                                c[22], c[23], c[24], c[25], c[26], c[27]);
                    if (n != 28)
                        abortRun($sformatf("test line %0d holds %0d of 28 columns",
                                           tests.size() + 1, n));
                    else
                        tests.push_back(packColumns(c));
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runLine(input testLine t);
        dcacheReq expReq;
        @(negedge clk);
        exeIn     = t.bus;
        flush     = t.flush;
        stall     = t.stall;
        interrupt = t.irq;
        disWr     = t.disWr;
        @(posedge clk);
        if (!t.stall)
            held = t.bus;
        #4;     // just ahead of the next falling edge
        if (t.mask[0]) begin
            checkWord("fwdResult", fwdResult, t.fwd);
            checkWord("fwdRegWr", {31'd0, fwdRegWr}, {31'd0, t.regWr});
            checkWord("fwdDst", {27'd0, fwdDst}, {27'd0, held.dst});
            checkWord("memPc", memPc, held.pc);
        end
        if (t.mask[1])
            checkWord("readOut", readOut, t.rdo);
        if (t.mask[2]) begin
            expReq.valid = t.dValid;
            expReq.write = held.store.dmWr;
            expReq.addr  = held.aluOut;
            expReq.wdata = held.outB;
            expReq.wstrb = held.byteEn;
            expReq.load  = held.load;
            checkDreq(dreq, expReq);
        end
        if (t.mask[3])
            checkEntry(excEntry, vecOut, {ifFlush, idFlush, exeFlush, memFlush},
                       t.entry, t.vector, {4{t.flushAll}});
        if (t.mask[4])
            checkWord("epc", epc, t.epc);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog allows 20 cycles per test line plus 100
    initial begin
        wait (loaded);
        #((numTests * 20 + 100) * 10);
        abortRun($sformatf("timeout: run did not finish in %0d cycles",
                           numTests * 20 + 100));
    end

    initial begin
        rstN      = 1'b0;
        exeIn     = '0;
        flush     = 1'b0;
        stall     = 1'b0;
        interrupt = 6'd0;
        disWr     = 1'b0;
        held      = '0;
        loaded    = 1'b0;
        numTests  = 0;
        loadTests();
        if (tests.size() == 0)
            abortRun("test file holds no test lines");
        else begin
            numTests = tests.size();
            loaded   = 1'b1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            rstN = 1'b1;
            foreach (tests[i])
                runLine(tests[i]);
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/memStageTests.txt ====
# v aluOut outB pc instr load store wbSel rdSel dst regWr byteEn except br mtc0 flush stall irq disWr
# then mask(1 fwd 2 readOut 4 dreq 8 entry 10 epc) fwd regWr readOut dreqValid entry vector flush epc
1 00001004 00000000 80000100 8c880004 a 0 1 0 08 1 f 00 0 0 0 0 00 0 0f 00001004 1 00000000 1 0 00000000 0 00000000
1 00002008 cafef00d 80000104 ac890008 0 6 1 0 00 0 f 00 0 0 0 0 00 0 0f 00002008 0 cafef00d 1 0 00000000 0 00000000
1 11111111 22222222 80000108 00000000 0 0 2 0 09 1 0 00 0 0 0 1 00 1 0f 00002008 0 cafef00d 1 0 00000000 0 00000000
1 11111111 22222222 80000108 00000000 0 0 2 0 09 1 0 00 0 0 0 1 00 1 0f 00002008 0 cafef00d 1 0 00000000 0 00000000
1 11111111 22222222 80000108 00000000 0 0 2 0 09 1 0 00 0 0 0 0 00 0 0f 22222222 1 22222222 0 0 00000000 0 00000000
1 00000000 00000000 80000110 0c000040 0 0 0 0 1f 1 0 00 1 0 0 0 00 0 0f 80000118 1 00000000 0 0 00000000 0 00000000
1 00000000 00400400 80000114 40886000 0 0 1 0 00 0 0 00 0 1 0 0 00 0 0f 00000000 0 00400400 0 0 00000000 0 00000000
1 00000000 00000000 80000118 40086000 0 0 1 3 08 1 0 00 0 0 0 0 01 0 0f 00000000 1 00400400 0 0 00000000 0 00000000
1 00000000 00000401 8000011c 40886000 0 0 1 0 00 0 0 00 0 1 0 0 01 1 0f 00000000 0 00000401 0 0 00000000 0 00000000
1 00000000 00000000 80000120 40086000 0 0 1 3 08 1 0 00 0 0 0 0 01 1 0f 00000000 1 00400400 0 0 00000000 0 00000000
1 00000000 9fc01000 80000124 40887801 0 0 1 0 00 0 0 00 0 1 0 0 00 0 0f 00000000 0 9fc01000 0 0 00000000 0 00000000
1 00000000 00000000 80000128 40087801 0 0 1 3 08 1 0 00 0 0 0 0 00 0 0f 00000000 1 9fc01000 0 0 00000000 0 00000000
1 00000077 00000000 80000200 00000000 0 0 1 0 0a 1 0 30 0 0 0 0 00 0 0f 00000077 0 00000000 0 1 bfc00380 1 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 00 0 0 00 0 0 0 0 00 0 18 00000000 0 00000000 0 0 00000000 0 80000200
1 00000000 00000000 80000204 40086800 0 0 1 3 08 1 0 00 0 0 0 0 00 0 0f 00000000 1 00000030 0 0 00000000 0 00000000
1 00000000 00000000 80000300 10000004 0 0 1 0 00 0 0 00 1 0 0 0 00 0 0f 00000000 0 00000000 0 0 00000000 0 00000000
1 00001235 00000000 80000304 8c8b0001 a 0 1 0 0b 1 f 4c 0 0 0 0 00 0 0f 00001235 0 00000000 0 1 bfc00380 1 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 00 0 0 00 0 0 0 0 00 0 18 00000000 0 00000000 0 0 00000000 0 80000300
1 00000000 00000000 80000308 40086800 0 0 1 3 08 1 0 00 0 0 0 0 00 0 0f 00000000 1 80000028 0 0 00000000 0 00000000
1 00000000 00000401 8000030c 40886000 0 0 1 0 00 0 0 00 0 1 0 0 00 0 0f 00000000 0 00000401 0 0 00000000 0 00000000
1 00000066 00000000 80000310 00000000 0 0 1 0 03 1 0 00 0 0 0 0 02 0 0f 00000066 1 00000000 0 0 00000000 0 00000000
1 0000abcd 12345678 80000311 00000000 0 6 1 0 00 0 f 82 0 0 0 0 00 0 0f 0000abcd 0 12345678 0 1 9fc01180 1 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 00 0 0 00 0 0 0 0 00 0 18 00000000 0 00000000 0 0 00000000 0 80000311
1 00000000 00000000 80000314 40084000 0 0 1 3 08 1 0 00 0 0 0 0 00 0 0f 00000000 1 80000311 0 0 00000000 0 00000000
1 00000000 00000000 80000318 42000018 0 0 1 0 00 0 0 01 0 0 0 0 00 0 1f 00000000 0 00000000 0 2 80000311 1 80000311
1 00000099 00000000 8000031c 00000000 0 0 1 0 04 1 0 00 0 0 1 0 01 0 08 00000000 0 00000000 0 0 00000000 0 00000000
1 00000055 00000000 80000400 00000000 0 0 1 0 02 1 0 00 0 0 0 0 01 0 1f 00000055 0 00000000 0 1 9fc01180 1 80000311
1 00000000 00000000 80000404 00000000 0 0 1 0 00 0 0 00 0 0 0 0 01 0 1f 00000000 0 00000000 0 0 00000000 0 80000400
1 00000000 00000000 80000408 40086800 0 0 1 3 08 1 0 00 0 0 0 0 01 0 0f 00000000 1 00000400 0 0 00000000 0 00000000

// ==== verilog/cp0Regs.sv ====
//==========================================================================
// cp0Regs holds the coprocessor 0 registers Status, Cause, EPC, BadVAddr,
// EBase, Count and Compare, with MTC0 writes, exception commit and ERET
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module cp0Regs
    import memStagePkg::*;
#(
    parameter logic [31:0] ebaseReset = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  memStageBus  stageReg,
    input  logic [4:0]  cp0Addr,
    input  logic [2:0]  cp0Sel,
    input  logic        disWr,
    input  logic [5:0]  interrupt,
    input  logic        take,
    input  logic        eretTake,
    input  excCode      code,
    output logic [31:0] cp0RdData,
    output cp0Status    status,
    output logic [31:0] epc
);

    logic        bev;
    logic [7:0]  im;
    logic        exl;
    logic        ie;
    logic        causeBd;
    logic        causeTi;       // set when count hits compare
    logic [7:2]  causeHw;
    logic [1:0]  causeSw;
    excCode      causeCode;
    logic [19:0] ebaseHi;       // EBase 31:12 with low bits reading zero
    logic [31:0] count;
    logic        countTick;
    logic [31:0] compare;
    logic [31:0] epcQ;
    logic [31:0] badVAddr;
    logic        mtc0En;
    logic [31:0] wrData;
    exceptFlags  flags;

    // exception or eret wins over a move in the same cycle
    assign mtc0En = stageReg.bundle.isMtc0 && !disWr && !take && !eretTake;
    assign wrData = stageReg.bundle.outB;
    assign flags  = stageReg.bundle.except;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bev       <= 1'b1;
            im        <= 8'd0;
            exl       <= 1'b0;
            ie        <= 1'b0;
            causeBd   <= 1'b0;
            causeTi   <= 1'b0;
            causeHw   <= 6'd0;
            causeSw   <= 2'd0;
            causeCode <= Int;
            ebaseHi   <= ebaseReset[31:12];
            count     <= 32'd0;
            countTick <= 1'b0;
            compare   <= 32'hffff_ffff;   // timer stays quiet until compare is set
        end else begin
            countTick <= ~countTick;
            if (countTick)
                count <= count + 32'd1;
            causeHw <= {interrupt[5] | causeTi, interrupt[4:0]};  // timer shares IP7
            if (count == compare)
                causeTi <= 1'b1;
            if (take) begin
                exl       <= 1'b1;
                causeCode <= code;
                causeBd   <= stageReg.inDelaySlot;
            end else if (eretTake) begin
                exl <= 1'b0;
            end else if (mtc0En) begin
                case (cp0Addr)
                    regStatus: begin
                        bev <= wrData[22];
                        im  <= wrData[15:8];
                        exl <= wrData[1];
                        ie  <= wrData[0];
                    end
                    regCause:   causeSw <= wrData[9:8];
                    regCompare: begin
                        compare <= wrData;
                        causeTi <= 1'b0;   // acknowledges the timer
                    end
                    regEbase: begin
                        if (cp0Sel == 3'd1)
                            ebaseHi <= wrData[31:12];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            epcQ <= stageReg.inDelaySlot ? stageReg.bundle.pc - 32'd4
                                         : stageReg.bundle.pc;
            if (code == AdEL || code == AdES)
                badVAddr <= flags.fetchAddrErr ? stageReg.bundle.pc
                                               : stageReg.bundle.aluOut;
        end else if (mtc0En) begin
            if (cp0Addr == regEpc)
                epcQ <= wrData;
        end
    end

    always_comb begin
        case (cp0Addr)
            regBadVAddr: cp0RdData = badVAddr;
            regCount:    cp0RdData = count;
            regCompare:  cp0RdData = compare;
            regStatus:   cp0RdData = {9'd0, bev, 6'd0, im, 6'd0, exl, ie};
            regCause:    cp0RdData = {causeBd, causeTi, 14'd0, causeHw, causeSw,
                                      1'b0, causeCode, 2'b00};
            regEpc:      cp0RdData = epcQ;
            regEbase:    cp0RdData = (cp0Sel == 3'd1) ? {ebaseHi, 12'd0} : 32'd0;
            default:     cp0RdData = 32'd0;
        endcase
    end

    assign status.bev   = bev;
    assign status.im    = im;
    assign status.exl   = exl;
    assign status.ie    = ie;
    assign status.ip    = {causeHw, causeSw};
    assign status.ebase = {ebaseHi, 12'd0};
    assign epc          = epcQ;

endmodule

`default_nettype wire

// ==== verilog/exceptionUnit.sv ====
//==========================================================================
// exceptionUnit: fixed-priority exception and interrupt arbiter, drives
// the pipeline flushes, the cause code and the entry vector
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module exceptionUnit
    import memStagePkg::*;
#(
    parameter logic [31:0] bootVector = 32'hbfc0_0380
) (
    input  memStageBus  stageReg,
    input  cp0Status    status,
    input  logic        disWr,
    input  logic [31:0] epc,
    output logic        take,
    output logic        eretTake,
    output excCode      code,
    output logic        ifFlush,
    output logic        idFlush,
    output logic        exeFlush,
    output logic        memFlush,
    output entrySel     excEntry,
    output logic [31:0] excVector
);

    exceptFlags flags;
    logic       intPending;
    logic       hasCause;
    logic       redirect;

    assign flags = stageReg.bundle.except;

    // masked interrupts only, and never while already in the handler
    assign intPending = stageReg.bundle.valid && status.ie && !status.exl
                        && |(status.ip & status.im);

    always_comb begin
        hasCause = 1'b1;
        code     = Int;
        if (intPending)
            code = Int;
        else if (flags.fetchAddrErr)
            code = AdEL;
        else if (flags.reservedInstr)
            code = RI;
        else if (flags.overflow)
            code = Ov;
        else if (flags.syscall)
            code = Sys;
        else if (flags.breakpoint)
            code = Bp;
        else if (flags.loadAddrErr)
            code = AdEL;
        else if (flags.storeAddrErr)
            code = AdES;
        else
            hasCause = 1'b0;
    end

    assign take     = hasCause && !disWr;   // no commit while stalled
    assign eretTake = flags.eret && !hasCause && !disWr;
    assign redirect = take || eretTake;

    assign ifFlush  = redirect;
    assign idFlush  = redirect;
    assign exeFlush = redirect;
    assign memFlush = redirect;

    always_comb begin
        excEntry  = none;
        excVector = 32'd0;
        if (take) begin
            excEntry  = memStagePkg::excVector;
            excVector = status.bev ? bootVector : status.ebase + 32'h0000_0180;
        end else if (eretTake) begin
            excEntry  = epcReturn;
            excVector = epc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memDecode.sv ====
//==========================================================================
// memDecode: execute-to-memory stage register with flush and stall,
// delay slot tracking and CP0 address decode
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module memDecode
    import memStagePkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       flush,
    input  logic       stall,
    input  exeMemBus   exeIn,
    output memStageBus stageReg,
    output logic [4:0] cp0Addr,
    output logic [2:0] cp0Sel
);

    exeMemBus bundleQ;
    logic     validQ;
    logic     slotQ;
    logic     lastBranch;   // last captured instr was a branch or jump
    logic     isCop0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ     <= 1'b0;
            slotQ      <= 1'b0;
            lastBranch <= 1'b0;
        end else if (!stall) begin
            if (flush) begin
                validQ     <= 1'b0;
                slotQ      <= 1'b0;
                lastBranch <= 1'b0;
            end else begin
                validQ <= exeIn.valid;
                if (exeIn.valid) begin   // bubbles keep the branch history
                    slotQ      <= lastBranch;
                    lastBranch <= exeIn.isBranchOrJump;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            bundleQ <= exeIn;
        end
    end

    // an invalid slot carries no side effects downstream
    always_comb begin
        stageReg              = '0;
        stageReg.bundle       = bundleQ;
        stageReg.bundle.valid = validQ;
        stageReg.inDelaySlot  = slotQ & validQ;
        if (!validQ) begin
            stageReg.bundle.regWr  = 1'b0;
            stageReg.bundle.load   = '0;
            stageReg.bundle.store  = '0;
            stageReg.bundle.except = '0;
            stageReg.bundle.isMtc0 = 1'b0;
        end
    end

    assign isCop0  = bundleQ.instr.rFormat.op == opCop0;
    assign cp0Addr = isCop0 ? bundleQ.instr.cop0Format.rd : 5'd0;
    assign cp0Sel  = isCop0 ? bundleQ.instr.cop0Format.sel : 3'd0;

endmodule

`default_nettype wire

// ==== verilog/memResult.sv ====
//==========================================================================
// memResult: forwarding result select, register read-out select and
// the dcache request
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module memResult
    import memStagePkg::*;
(
    input  memStageBus  stageReg,
    input  logic [31:0] cp0RdData,
    input  logic        take,
    output logic [31:0] fwdResult,
    output logic [31:0] readOut,
    output logic [4:0]  fwdDst,
    output logic        fwdRegWr,
    output dcacheReq    dreq
);

    exeMemBus   b;
    logic       memOp;
    logic       selfFault;    // the access itself raised a cause

    assign b = stageReg.bundle;

    always_comb begin
        case (b.wbSel)
            pcPlus8: fwdResult = b.pc + 32'd8;
            aluOut:  fwdResult = b.aluOut;
            outB:    fwdResult = b.outB;
            default: fwdResult = b.aluOut;
        endcase
    end

    assign readOut  = (b.rdSel == cp0) ? cp0RdData : b.outB;
    assign fwdDst   = b.dst;
    assign fwdRegWr = b.regWr && !take;

    // eret is not a fault, every other flag blocks the access
    assign memOp     = b.load.readMem || b.store.dmWr;
    assign selfFault = |b.except[7:1];

    assign dreq.valid = memOp && !take && !selfFault;
    assign dreq.write = b.store.dmWr;
    assign dreq.addr  = b.aluOut;
    assign dreq.wdata = b.outB;
    assign dreq.wstrb = b.byteEn;
    assign dreq.load  = b.load;

endmodule

`default_nettype wire

// ==== verilog/memStage.sv ====
//==========================================================================
// memStage: memory stage of the five-stage MIPS32 pipeline, with stage
// register, exception arbitration, CP0 and result select
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module memStage
    import memStagePkg::*;
#(
    parameter logic [31:0] bootVector = 32'hbfc0_0380,
    parameter logic [31:0] ebaseReset = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  exeMemBus    exeIn,
    input  logic        flush,
    input  logic        stall,
    input  logic [5:0]  interrupt,
    input  logic        disWr,
    output logic [31:0] fwdResult,
    output logic [4:0]  fwdDst,
    output logic        fwdRegWr,
    output logic [31:0] readOut,
    output dcacheReq    dreq,
    output logic        ifFlush,
    output logic        idFlush,
    output logic        exeFlush,
    output logic        memFlush,
    output entrySel     excEntry,
    output logic [31:0] excVector,
    output logic [31:0] epc,
    output logic [31:0] memPc
);

    memStageBus  stageReg;
    logic [4:0]  cp0Addr;
    logic [2:0]  cp0Sel;
    cp0Status    status;
    logic        take;
    logic        eretTake;
    excCode      code;
    logic [31:0] cp0RdData;

    assign memPc = stageReg.bundle.pc;

    memDecode memDecode_inst (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (flush),
        .stall    (stall),
        .exeIn    (exeIn),
        .stageReg (stageReg),
        .cp0Addr  (cp0Addr),
        .cp0Sel   (cp0Sel)
    );

    exceptionUnit #(
        .bootVector (bootVector)
    ) exceptionUnit_inst (
        .stageReg  (stageReg),
        .status    (status),
        .disWr     (disWr),
        .epc       (epc),
        .take      (take),
        .eretTake  (eretTake),
        .code      (code),
        .ifFlush   (ifFlush),
        .idFlush   (idFlush),
        .exeFlush  (exeFlush),
        .memFlush  (memFlush),
        .excEntry  (excEntry),
        .excVector (excVector)
    );

    cp0Regs #(
        .ebaseReset (ebaseReset)
    ) cp0Regs_inst (
        .clk       (clk),
        .rstN      (rstN),
        .stageReg  (stageReg),
        .cp0Addr   (cp0Addr),
        .cp0Sel    (cp0Sel),
        .disWr     (disWr),
        .interrupt (interrupt),
        .take      (take),
        .eretTake  (eretTake),
        .code      (code),
        .cp0RdData (cp0RdData),
        .status    (status),
        .epc       (epc)
    );

    memResult memResult_inst (
        .stageReg  (stageReg),
        .cp0RdData (cp0RdData),
        .take      (take),
        .fwdResult (fwdResult),
        .readOut   (readOut),
        .fwdDst    (fwdDst),
        .fwdRegWr  (fwdRegWr),
        .dreq      (dreq)
    );

endmodule

`default_nettype wire

// ==== verilog/memStagePkg.sv ====
//==========================================================================
// memStagePkg: shared types of the MIPS32 memory stage, covering pipeline
// bundles, the CP0 view of the instruction word, exception codes and
// the dcache request
//==========================================================================
`default_nettype none

package memStagePkg;

    typedef struct packed {
        logic       readMem;
        logic       signExt;
        logic [1:0] size;       // 0 byte, 1 half, 2 word
    } loadType;

    typedef struct packed {
        logic       dmWr;
        logic [1:0] size;
    } storeType;

    typedef enum logic [1:0] {
        pcPlus8 = 2'd0,         // link address for jal/bal
        aluOut  = 2'd1,
        outB    = 2'd2
    } wbSel;

    typedef enum logic [1:0] {
        gpr = 2'd0,
        hi  = 2'd1,
        lo  = 2'd2,
        cp0 = 2'd3              // only this one changes readOut
    } regsRdSel;

    // one bit per cause raised upstream, eret rides along as a pseudo cause
    typedef struct packed {
        logic fetchAddrErr;
        logic reservedInstr;
        logic overflow;
        logic syscall;
        logic breakpoint;
        logic loadAddrErr;
        logic storeAddrErr;
        logic eret;
    } exceptFlags;

    typedef enum logic [4:0] {
        Int  = 5'd0,
        AdEL = 5'd4,
        AdES = 5'd5,
        Sys  = 5'd8,
        Bp   = 5'd9,
        RI   = 5'd10,
        Ov   = 5'd12
    } excCode;

    typedef enum logic [1:0] {
        none      = 2'd0,
        excVector = 2'd1,
        epcReturn = 2'd2
    } entrySel;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] copOp;      // mf/mt/co
        logic [4:0] rt;
        logic [4:0] rd;
        logic [7:0] zeros;
        logic [2:0] sel;
    } cop0Fields;

    typedef union packed {
        rFields    rFormat;
        cop0Fields cop0Format;
    } instrWord;

    localparam logic [5:0] opCop0 = 6'b010000;

    // CP0 register numbers
    localparam logic [4:0] regBadVAddr = 5'd8;
    localparam logic [4:0] regCount    = 5'd9;
    localparam logic [4:0] regCompare  = 5'd11;
    localparam logic [4:0] regStatus   = 5'd12;
    localparam logic [4:0] regCause    = 5'd13;
    localparam logic [4:0] regEpc      = 5'd14;
    localparam logic [4:0] regEbase    = 5'd15;   // sel 1, PRId at sel 0

    typedef struct packed {
        logic        valid;
        logic [31:0] aluOut;
        logic [31:0] outB;
        logic [31:0] pc;
        instrWord    instr;
        loadType     load;
        storeType    store;
        wbSel        wbSel;
        regsRdSel    rdSel;
        logic [4:0]  dst;
        logic        regWr;
        logic [3:0]  byteEn;
        exceptFlags  except;
        logic        isBranchOrJump;
        logic        isMtc0;
    } exeMemBus;

    typedef struct packed {
        exeMemBus bundle;
        logic     inDelaySlot;
    } memStageBus;

    typedef struct packed {
        logic        bev;
        logic [7:0]  im;
        logic        exl;
        logic        ie;
        logic [7:0]  ip;        // hardware 7:2, software 1:0
        logic [31:0] ebase;
    } cp0Status;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        loadType     load;
    } dcacheReq;

endpackage

`default_nettype wire
